// ==== source/eth_tx_params.svh ====
`ifndef ETH_TX_PARAMS_SVH
`define ETH_TX_PARAMS_SVH

// field lengths in dibits, four dibits per byte
`define ETH_PREAMBLE_LEN  28
`define ETH_SFD_LEN       4
`define ETH_MAC_LEN       24
`define ETH_TYPE_LEN      8
`define ETH_PAYLOAD_LEN   8
// pad brings the 2 payload bytes up to the 46 byte minimum
`define ETH_PAD_LEN       176
`define ETH_FCS_LEN       16
// 96 bit times at two bits per clock
`define ETH_IPG_LEN       48

`define ETH_PREAMBLE_BYTE 8'h55
`define ETH_SFD_BYTE      8'hD5

// apb register byte offsets
`define ETH_REG_CTRL      8'h00
`define ETH_REG_DST_LO    8'h04
`define ETH_REG_DST_HI    8'h08
`define ETH_REG_SRC_LO    8'h0C
`define ETH_REG_SRC_HI    8'h10
`define ETH_REG_TYPE_DATA 8'h14

`endif

// ==== source/eth_tx_pkg.sv ====
`default_nettype none

package eth_tx_pkg;

    // framer states, in wire order of the fields
    typedef enum logic [3:0] {
        IDLE      = 4'd0,
        PREAMBLE  = 4'd1,
        SFD       = 4'd2,
        DST_MAC   = 4'd3,
        SRC_MAC   = 4'd4,
        ETHERTYPE = 4'd5,
        PAYLOAD   = 4'd6,
        ZERO_PAD  = 4'd7,
        FCS       = 4'd8,
        IPG       = 4'd9
    } tx_state_e;

    // decoded apb register select
    typedef enum logic [2:0] {
        CTRL      = 3'd0,
        DST_LO    = 3'd1,
        DST_HI    = 3'd2,
        SRC_LO    = 3'd3,
        SRC_HI    = 3'd4,
        TYPE_DATA = 3'd5,
        NONE      = 3'd6
    } reg_sel_e;

endpackage

`default_nettype wire

// ==== source/frame_cfg_if.sv ====
`timescale 1ns/10ps
`default_nettype none

interface frame_cfg_if;
    logic [47:0] dst_mac;
    logic [47:0] src_mac;
    logic [15:0] ethertype;
    logic [15:0] payload;
    // one cycle pulse from the register block
    logic        start;
    logic        busy;

    modport regs (output dst_mac, src_mac, ethertype, payload, start, input busy);
    modport mac  (input dst_mac, src_mac, ethertype, payload, start, output busy);
endinterface

`default_nettype wire

// ==== source/eth_tx_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "eth_tx_params.svh"

module eth_tx_regs (
    input  wire         clk,
    input  wire         arst_n,
    input  wire  [7:0]  paddr,
    input  wire         psel,
    input  wire         penable,
    input  wire         pwrite,
    input  wire  [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    frame_cfg_if.regs   cfg
);
    eth_tx_pkg::reg_sel_e sel;
    logic        access;
    logic        wr_en;
    logic [31:0] dst_lo;
    logic [15:0] dst_hi;
    logic [31:0] src_lo;
    logic [15:0] src_hi;
    logic [31:0] type_data;
    logic        start_q;

    always_comb begin
        case (paddr)
            `ETH_REG_CTRL:      sel = eth_tx_pkg::CTRL;
            `ETH_REG_DST_LO:    sel = eth_tx_pkg::DST_LO;
            `ETH_REG_DST_HI:    sel = eth_tx_pkg::DST_HI;
            `ETH_REG_SRC_LO:    sel = eth_tx_pkg::SRC_LO;
            `ETH_REG_SRC_HI:    sel = eth_tx_pkg::SRC_HI;
            `ETH_REG_TYPE_DATA: sel = eth_tx_pkg::TYPE_DATA;
            default:            sel = eth_tx_pkg::NONE;
        endcase
    end

    // no wait states, every access phase completes
    assign pready  = 1'b1;
    assign access  = psel & penable;
    // frame settings are locked while a frame is on the wire
    assign pslverr = access & ((sel == eth_tx_pkg::NONE) | (pwrite & cfg.busy));
    assign wr_en   = access & pwrite & ~pslverr;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dst_lo    <= '0;
            dst_hi    <= '0;
            src_lo    <= '0;
            src_hi    <= '0;
            type_data <= '0;
            start_q   <= 1'b0;
        end else begin
            start_q <= 1'b0;
            if (wr_en) begin
                case (sel)
                    eth_tx_pkg::CTRL:      start_q   <= pwdata[0];
                    eth_tx_pkg::DST_LO:    dst_lo    <= pwdata;
                    eth_tx_pkg::DST_HI:    dst_hi    <= pwdata[15:0];
                    eth_tx_pkg::SRC_LO:    src_lo    <= pwdata;
                    eth_tx_pkg::SRC_HI:    src_hi    <= pwdata[15:0];
                    eth_tx_pkg::TYPE_DATA: type_data <= pwdata;
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        case (sel)
            eth_tx_pkg::CTRL:      prdata = {31'd0, cfg.busy};
            eth_tx_pkg::DST_LO:    prdata = dst_lo;
            eth_tx_pkg::DST_HI:    prdata = {16'd0, dst_hi};
            eth_tx_pkg::SRC_LO:    prdata = src_lo;
            eth_tx_pkg::SRC_HI:    prdata = {16'd0, src_hi};
            eth_tx_pkg::TYPE_DATA: prdata = type_data;
            default:               prdata = 32'd0;
        endcase
    end

    assign cfg.start     = start_q;
    assign cfg.dst_mac   = {dst_hi, dst_lo};
    assign cfg.src_mac   = {src_hi, src_lo};
    assign cfg.ethertype = type_data[31:16];
    assign cfg.payload   = type_data[15:0];

endmodule

`default_nettype wire

// ==== source/dibit_reorder.sv ====
`timescale 1ns/10ps
`default_nettype none

module dibit_reorder (
    input  wire        clk,
    input  wire        arst_n,
    input  wire        in_valid,
    input  wire  [1:0] in_dibit,
    output logic       out_valid,
    output logic [1:0] out_dibit
);
    // first three dibits of the byte being collected, msb first
    logic [5:0] fill;
    logic [1:0] fill_cnt;
    logic       byte_done;
    // completed byte, shifted out from the low end
    logic [7:0] replay;
    logic [2:0] replay_left;

    assign byte_done = in_valid && (fill_cnt == 2'd3);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fill_cnt    <= 2'd0;
            replay_left <= 3'd0;
        end else begin
            if (in_valid)
                fill_cnt <= fill_cnt + 2'd1;
            if (byte_done)
                replay_left <= 3'd4;
            else if (replay_left != 3'd0)
                replay_left <= replay_left - 3'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid)
            fill <= {fill[3:0], in_dibit};
        // load lands as the previous byte's last dibit leaves
        if (byte_done)
            replay <= {fill, in_dibit};
        else
            replay <= {2'b00, replay[7:2]};
    end

    assign out_valid = (replay_left != 3'd0);
    assign out_dibit = replay[1:0];

endmodule

`default_nettype wire

// ==== source/eth_crc32.sv ====
`timescale 1ns/10ps
`default_nettype none

module eth_crc32 (
    input  wire         clk,
    input  wire         arst_n,
    input  wire         clear,
    input  wire         enable,
    input  wire  [1:0]  dibit,
    output logic [31:0] crc
);
    // reflected form of 0x04C11DB7
    localparam logic [31:0] POLY = 32'hEDB88320;

    logic [31:0] lfsr;

    function automatic logic [31:0] crc_step(input logic [31:0] r, input logic b);
        logic fb;
        fb = r[0] ^ b;
        crc_step = (r >> 1) ^ (fb ? POLY : 32'd0);
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lfsr <= '1;
        end else if (clear) begin
            lfsr <= '1;
        end else if (enable) begin
            // dibit[0] is first on the wire
            lfsr <= crc_step(crc_step(lfsr, dibit[0]), dibit[1]);
        end
    end

    // complement and reverse so crc[31] is the first fcs bit out
    always_comb begin
        for (int i = 0; i < 32; i++)
            crc[i] = ~lfsr[31-i];
    end

endmodule

`default_nettype wire

// ==== source/mac_tx.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "eth_tx_params.svh"

module mac_tx (
    input  wire         clk,
    input  wire         arst_n,
    frame_cfg_if.mac    cfg,
    input  wire         ro_valid,
    input  wire  [1:0]  ro_dibit,
    input  wire  [31:0] crc,
    output logic        in_valid,
    output logic [1:0]  in_dibit,
    output logic        crc_clear,
    output logic        crc_enable,
    output logic        txen,
    output logic [1:0]  txd
);
    // cycles from a dibit entering the reorder stage to its byte slot on the wire
    localparam int REORDER_LAT = 4;

    eth_tx_pkg::tx_state_e state;
    eth_tx_pkg::tx_state_e state_next;
    logic [7:0]  cnt;
    logic [7:0]  len;
    logic        last;
    logic        launch;
    logic [47:0] dst_q;
    logic [47:0] src_q;
    logic [15:0] type_q;
    logic [15:0] data_q;
    logic        crc_field;
    logic [REORDER_LAT-1:0] crc_tag;
    logic [1:0]  fcs_pair;

    // dibit idx of a len-dibit field, most significant first
    function automatic logic [1:0] msb_dibit(input logic [47:0] field, input int len_d,
                                             input int idx);
        msb_dibit = field[2*(len_d-idx)-2 +: 2];
    endfunction

    assign launch    = (state == eth_tx_pkg::IDLE) && cfg.start;
    assign crc_clear = launch;
    assign cfg.busy  = (state != eth_tx_pkg::IDLE);

    always_comb begin
        case (state)
            eth_tx_pkg::PREAMBLE:  len = 8'(`ETH_PREAMBLE_LEN);
            eth_tx_pkg::SFD:       len = 8'(`ETH_SFD_LEN);
            eth_tx_pkg::DST_MAC:   len = 8'(`ETH_MAC_LEN);
            eth_tx_pkg::SRC_MAC:   len = 8'(`ETH_MAC_LEN);
            eth_tx_pkg::ETHERTYPE: len = 8'(`ETH_TYPE_LEN);
            eth_tx_pkg::PAYLOAD:   len = 8'(`ETH_PAYLOAD_LEN);
            // extra cycles let the last pad byte drain out of the reorder stage
            eth_tx_pkg::ZERO_PAD:  len = 8'(`ETH_PAD_LEN + REORDER_LAT);
            eth_tx_pkg::FCS:       len = 8'(`ETH_FCS_LEN);
            eth_tx_pkg::IPG:       len = 8'(`ETH_IPG_LEN);
            default:               len = 8'd1;
        endcase
    end

    always_comb begin
        case (state)
            eth_tx_pkg::PREAMBLE:  state_next = eth_tx_pkg::SFD;
            eth_tx_pkg::SFD:       state_next = eth_tx_pkg::DST_MAC;
            eth_tx_pkg::DST_MAC:   state_next = eth_tx_pkg::SRC_MAC;
            eth_tx_pkg::SRC_MAC:   state_next = eth_tx_pkg::ETHERTYPE;
            eth_tx_pkg::ETHERTYPE: state_next = eth_tx_pkg::PAYLOAD;
            eth_tx_pkg::PAYLOAD:   state_next = eth_tx_pkg::ZERO_PAD;
            eth_tx_pkg::ZERO_PAD:  state_next = eth_tx_pkg::FCS;
            eth_tx_pkg::FCS:       state_next = eth_tx_pkg::IPG;
            default:               state_next = eth_tx_pkg::IDLE;
        endcase
    end

    assign last = (cnt == len - 8'd1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= eth_tx_pkg::IDLE;
            cnt   <= 8'd0;
        end else if (state == eth_tx_pkg::IDLE) begin
            cnt <= 8'd0;
            if (cfg.start)
                state <= eth_tx_pkg::PREAMBLE;
        end else if (last) begin
            cnt   <= 8'd0;
            state <= state_next;
        end else begin
            cnt <= cnt + 8'd1;
        end
    end

    // private copy so register writes cannot disturb a frame in flight
    always_ff @(posedge clk) begin
        if (launch) begin
            dst_q  <= cfg.dst_mac;
            src_q  <= cfg.src_mac;
            type_q <= cfg.ethertype;
            data_q <= cfg.payload;
        end
    end

    always_comb begin
        in_valid = 1'b1;
        in_dibit = 2'b00;
        case (state)
            eth_tx_pkg::PREAMBLE:  in_dibit = msb_dibit({40'd0, `ETH_PREAMBLE_BYTE}, 4, cnt[1:0]);
            eth_tx_pkg::SFD:       in_dibit = msb_dibit({40'd0, `ETH_SFD_BYTE}, 4, cnt[1:0]);
            eth_tx_pkg::DST_MAC:   in_dibit = msb_dibit(dst_q, `ETH_MAC_LEN, cnt);
            eth_tx_pkg::SRC_MAC:   in_dibit = msb_dibit(src_q, `ETH_MAC_LEN, cnt);
            eth_tx_pkg::ETHERTYPE: in_dibit = msb_dibit({32'd0, type_q}, `ETH_TYPE_LEN, cnt);
            eth_tx_pkg::PAYLOAD:   in_dibit = msb_dibit({32'd0, data_q}, `ETH_PAYLOAD_LEN, cnt);
            eth_tx_pkg::ZERO_PAD:  in_valid = (cnt < 8'(`ETH_PAD_LEN));
            default:               in_valid = 1'b0;
        endcase
    end

    // crc covers dst mac through pad, tag delayed to match the reorder output
    assign crc_field = in_valid && (state inside {eth_tx_pkg::DST_MAC, eth_tx_pkg::SRC_MAC,
                                                  eth_tx_pkg::ETHERTYPE, eth_tx_pkg::PAYLOAD,
                                                  eth_tx_pkg::ZERO_PAD});

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n)
            crc_tag <= '0;
        else
            crc_tag <= {crc_tag[REORDER_LAT-2:0], crc_field};
    end

    assign crc_enable = crc_tag[REORDER_LAT-1];

    // fcs bits leave in wire order, higher index of each pair on txd[0]
    assign fcs_pair = crc[30 - 2*cnt[3:0] +: 2];

    always_comb begin
        if (state == eth_tx_pkg::FCS) begin
            txen = 1'b1;
            txd  = {fcs_pair[0], fcs_pair[1]};
        end else begin
            txen = ro_valid;
            txd  = ro_valid ? ro_dibit : 2'b00;
        end
    end

endmodule

`default_nettype wire

// ==== source/eth_tx_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module eth_tx_top (
    input  wire         clk,
    input  wire         arst_n,
    input  wire  [7:0]  paddr,
    input  wire         psel,
    input  wire         penable,
    input  wire         pwrite,
    input  wire  [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr,
    output logic        txen,
    output logic [1:0]  txd
);
    logic        ro_in_valid;
    logic [1:0]  ro_in_dibit;
    logic        ro_out_valid;
    logic [1:0]  ro_out_dibit;
    logic        crc_clear;
    logic        crc_enable;
    logic [31:0] crc;

    frame_cfg_if cfg_bus ();

    eth_tx_regs u_regs (
        .clk     (clk),
        .arst_n  (arst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .cfg     (cfg_bus.regs)
    );

    mac_tx u_mac (
        .clk        (clk),
        .arst_n     (arst_n),
        .cfg        (cfg_bus.mac),
        .ro_valid   (ro_out_valid),
        .ro_dibit   (ro_out_dibit),
        .crc        (crc),
        .in_valid   (ro_in_valid),
        .in_dibit   (ro_in_dibit),
        .crc_clear  (crc_clear),
        .crc_enable (crc_enable),
        .txen       (txen),
        .txd        (txd)
    );

    dibit_reorder u_reorder (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (ro_in_valid),
        .in_dibit  (ro_in_dibit),
        .out_valid (ro_out_valid),
        .out_dibit (ro_out_dibit)
    );

    // crc sees the dibits in the same order as the wire
    eth_crc32 u_crc (
        .clk    (clk),
        .arst_n (arst_n),
        .clear  (crc_clear),
        .enable (crc_enable),
        .dibit  (ro_out_dibit),
        .crc    (crc)
    );

endmodule

`default_nettype wire

// ==== tb/tb_eth_tx.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "eth_tx_params.svh"

module tb_eth_tx;

    localparam int FRAME_DIBITS = `ETH_PREAMBLE_LEN + `ETH_SFD_LEN + 2 * `ETH_MAC_LEN
                                + `ETH_TYPE_LEN + `ETH_PAYLOAD_LEN + `ETH_PAD_LEN + `ETH_FCS_LEN;
    localparam int FRAME_BYTES  = FRAME_DIBITS / 4;
    localparam int HDR_BYTES    = (`ETH_PREAMBLE_LEN + `ETH_SFD_LEN) / 4;
    localparam int FCS_BYTE     = FRAME_BYTES - `ETH_FCS_LEN / 4;
    localparam int FCS_DIBIT    = FRAME_DIBITS - `ETH_FCS_LEN;
    localparam int CAP_DEPTH    = FRAME_DIBITS + 32;

    logic        clk;
    logic        arst_n;
    logic [7:0]  paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
    wire  [31:0] prdata;
    wire         pready;
    wire         pslverr;
    wire         txen;
    wire  [1:0]  txd;

    integer      errors;
    integer      seed;
    integer      nvec;
    integer      fd;
    integer      cap_n;
    integer      bursts;
    logic        txen_q;
    logic [1:0]  cap [0:CAP_DEPTH-1];
    logic [7:0]  exp_bytes [0:FRAME_BYTES-1];
    reg   [8*160-1:0] line;
    logic [47:0] v_dst;
    logic [47:0] v_src;
    logic [15:0] v_type;
    logic [15:0] v_data;
    logic [31:0] rd_word;

    eth_tx_top UUT (
        .clk     (clk),
        .arst_n  (arst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .txen    (txen),
        .txd     (txd)
    );

    always #10 clk = ~clk;

    // wire monitor, sampled mid cycle
    always @(negedge clk) begin
        if (txen === 1'b1) begin
            if (cap_n < CAP_DEPTH)
                cap[cap_n] = txd;
            cap_n = cap_n + 1;
            if (txen_q !== 1'b1)
                bursts = bursts + 1;
        end
        txen_q = txen;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("errors: %0d", errors + 1);
        $display("ERRORS FOUND");
        $finish;
    endtask

    task automatic idle(input integer n);
        repeat (n) @(posedge clk);
        #2;
    endtask

    // all apb tasks start and end 2 ns after a rising edge
    task automatic apb_write(input logic [7:0] addr, input logic [31:0] data,
                             input logic want_err);
        paddr   = addr;
        pwdata  = data;
        pwrite  = 1'b1;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #2;
        penable = 1'b1;
        #1;
        if (pready !== 1'b1) begin
            errors = errors + 1;
            $display("Error: pready on write to %h got %h expected %h", addr, pready, 1'b1);
        end
        if (pslverr !== want_err) begin
            errors = errors + 1;
            $display("Error: pslverr on write to %h got %h expected %h", addr, pslverr, want_err);
        end
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] data,
                            input logic want_err);
        paddr   = addr;
        pwrite  = 1'b0;
        psel    = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #2;
        penable = 1'b1;
        #1;
        data = prdata;
        if (pready !== 1'b1) begin
            errors = errors + 1;
            $display("Error: pready on read of %h got %h expected %h", addr, pready, 1'b1);
        end
        if (pslverr !== want_err) begin
            errors = errors + 1;
            $display("Error: pslverr on read of %h got %h expected %h", addr, pslverr, want_err);
        end
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic check_read(input logic [7:0] addr, input logic [31:0] want);
        logic [31:0] rd;
        apb_read(addr, rd, 1'b0);
        if (rd !== want) begin
            errors = errors + 1;
            $display("Error: prdata at %h got %h expected %h", addr, rd, want);
        end
    endtask

    // ieee 802.3 crc, reflected, over exp_bytes[first..last-1]
    function automatic logic [31:0] crc32_over(input int first, input int last);
        logic [31:0] r;
        int i;
        int b;
        r = 32'hFFFF_FFFF;
        for (i = first; i < last; i++) begin
            r = r ^ {24'd0, exp_bytes[i]};
            for (b = 0; b < 8; b++)
                r = r[0] ? ((r >> 1) ^ 32'hEDB8_8320) : (r >> 1);
        end
        crc32_over = r;
    endfunction

    task automatic build_expected(input logic [47:0] dst, input logic [47:0] src,
                                  input logic [15:0] etype, input logic [15:0] data);
        integer i;
        logic [31:0] fcs;
        for (i = 0; i < FRAME_BYTES; i++)
            exp_bytes[i] = 8'h00;
        for (i = 0; i < HDR_BYTES - 1; i++)
            exp_bytes[i] = `ETH_PREAMBLE_BYTE;
        exp_bytes[HDR_BYTES - 1] = `ETH_SFD_BYTE;
        // addresses go out most significant byte first
        for (i = 0; i < 6; i++) begin
            exp_bytes[HDR_BYTES + i]     = dst[47 - 8 * i -: 8];
            exp_bytes[HDR_BYTES + 6 + i] = src[47 - 8 * i -: 8];
        end
        exp_bytes[HDR_BYTES + 12] = etype[15:8];
        exp_bytes[HDR_BYTES + 13] = etype[7:0];
        exp_bytes[HDR_BYTES + 14] = data[15:8];
        exp_bytes[HDR_BYTES + 15] = data[7:0];
        fcs = ~crc32_over(HDR_BYTES, FCS_BYTE);
        for (i = 0; i < 4; i++)
            exp_bytes[FCS_BYTE + i] = fcs[8 * i +: 8];
    endtask

    task automatic check_frame(input integer vec);
        integer i;
        logic [1:0] want;
        if (bursts != 1) begin
            errors = errors + 1;
            $display("vector %0d: txen was not one contiguous burst (%0d bursts)", vec, bursts);
        end
        if (cap_n != FRAME_DIBITS) begin
            errors = errors + 1;
            $display("Error: txen cycles got %h expected %h", cap_n, FRAME_DIBITS);
        end
        for (i = 0; i < FRAME_DIBITS && i < cap_n; i++) begin
            // each byte leaves lsb dibit first
            want = exp_bytes[i / 4][2 * (i % 4) +: 2];
            if (cap[i] !== want) begin
                errors = errors + 1;
                $display("Error: vector %0d %s txd dibit %0d got %h expected %h", vec,
                         (i >= FCS_DIBIT) ? "fcs" : "frame", i, cap[i], want);
            end
        end
    endtask

    task automatic wait_for_txen();
        integer n;
        n = 0;
        while (txen !== 1'b1 && n < 20) begin
            idle(1);
            n = n + 1;
        end
        if (txen !== 1'b1)
            abort_run("timeout: txen did not rise after start");
    endtask

    task automatic wait_until_idle();
        integer n;
        logic [31:0] st;
        n  = 0;
        st = 32'd1;
        while (st[0] && n < 400) begin
            apb_read(`ETH_REG_CTRL, st, 1'b0);
            n = n + 1;
        end
        if (st[0])
            abort_run("timeout: busy stayed high after the frame");
    endtask

    task automatic run_frame(input integer vec, input logic [47:0] dst, input logic [47:0] src,
                             input logic [15:0] etype, input logic [15:0] data);
        idle(($random(seed) & 15) + 2);
        apb_write(`ETH_REG_DST_LO, dst[31:0], 1'b0);
        apb_write(`ETH_REG_DST_HI, {16'd0, dst[47:32]}, 1'b0);
        apb_write(`ETH_REG_SRC_LO, src[31:0], 1'b0);
        apb_write(`ETH_REG_SRC_HI, {16'd0, src[47:32]}, 1'b0);
        apb_write(`ETH_REG_TYPE_DATA, {etype, data}, 1'b0);
        check_read(`ETH_REG_DST_LO, dst[31:0]);
        check_read(`ETH_REG_DST_HI, {16'd0, dst[47:32]});
        check_read(`ETH_REG_SRC_LO, src[31:0]);
        check_read(`ETH_REG_SRC_HI, {16'd0, src[47:32]});
        check_read(`ETH_REG_TYPE_DATA, {etype, data});
        check_read(`ETH_REG_CTRL, 32'd0);
        build_expected(dst, src, etype, data);
        cap_n  = 0;
        bursts = 0;
        apb_write(`ETH_REG_CTRL, 32'd1, 1'b0);
        wait_for_txen();
        check_read(`ETH_REG_CTRL, 32'd1);
        if (vec == 0) begin
            // writes during a frame are refused and leave the frame intact
            apb_write(`ETH_REG_DST_LO, ~dst[31:0], 1'b1);
            apb_write(`ETH_REG_CTRL, 32'd1, 1'b1);
            check_read(`ETH_REG_DST_LO, dst[31:0]);
        end
        wait_until_idle();
        if (txen !== 1'b0) begin
            errors = errors + 1;
            $display("Error: txen after frame got %h expected %h", txen, 1'b0);
        end
        check_frame(vec);
    endtask

    initial begin
        clk     = 1'b0;
        arst_n  = 1'b0;
        paddr   = 8'd0;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        pwdata  = 32'd0;
        errors  = 0;
        seed    = 83;
        nvec    = 0;
        cap_n   = 0;
        bursts  = 0;
        txen_q  = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        arst_n = 1'b1;
        if (txen !== 1'b0 || pslverr !== 1'b0) begin
            errors = errors + 1;
            $display("Error: txen/pslverr after reset got %h/%h expected 0/0", txen, pslverr);
        end
        check_read(`ETH_REG_CTRL, 32'd0);
        check_read(`ETH_REG_DST_LO, 32'd0);
        check_read(`ETH_REG_TYPE_DATA, 32'd0);
        apb_read(8'h40, rd_word, 1'b1);
        apb_write(8'h40, 32'h1234_5678, 1'b1);
        fd = $fopen("tb/eth_tx_vectors.txt", "r");
        if (fd == 0)
            abort_run("could not open tb/eth_tx_vectors.txt");
        while (!$feof(fd)) begin
            line = 0;
            void'($fgets(line, fd));
            if ($sscanf(line, "%h %h %h %h", v_dst, v_src, v_type, v_data) == 4) begin
                run_frame(nvec, v_dst, v_src, v_type, v_data);
                nvec = nvec + 1;
            end
        end
        $fclose(fd);
        if (nvec == 0) begin
            errors = errors + 1;
            $display("no frame vectors were found in the vector file");
        end
        $display("frames: %0d errors: %0d", nvec, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb/eth_tx_vectors.txt ====
// columns: destination mac, source mac, ethertype, payload word (all hex)
// the fcs of each frame follows from these fields by the ieee 802.3 crc
ffffffffffff 001122334455 0800 a55a
0a1b2c3d4e5f 02deadbeef01 88b5 1234
000000000000 000000000000 0000 0000
123456789abc fedcba987654 86dd ffff
01005e0000fb 3c970e8a11c2 0806 0001

// ==== flist.f ====
+incdir+source
source/eth_tx_pkg.sv
source/frame_cfg_if.sv
source/eth_tx_regs.sv
source/dibit_reorder.sv
source/eth_crc32.sv
source/mac_tx.sv
source/eth_tx_top.sv
tb/tb_eth_tx.sv
